/* rhd2132_acq.f */
+incdir+include
source/rhd_pkg.sv
source/rhd_spi_frame.sv
source/rhd_sequencer.sv
source/sample_fifo.sv
source/sample_reader.sv
source/rhd_acq_top.sv
dv/rhd_chip_model.sv
dv/rhd_acq_props.sv
dv/rhd_acq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the acquisition testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f rhd2132_acq.f \
    --top-module rhd_acq_tb -o rhd_acq_sim || exit 1
sim_out=$(./obj_dir/rhd_acq_sim)
echo "$sim_out"
echo "$sim_out" | grep -qF '*** PASSED ***' && echo "Result: pass" && exit 0 || echo "Result: fail" && exit 1

/* dv/rhd_acq_tb.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module rhd_acq_tb;
    import rhd_pkg::*;

    localparam int FRAME_CYCLES   = `RHD_FRAME_SLOTS * `RHD_SCK_DIV + 1;
    localparam int BOOT_FRAMES    = `RHD_PRE_READS + `RHD_REG_COUNT + 1 + `RHD_POST_READS;
    localparam int RUN_FRAMES     = BOOT_FRAMES + 2 * `RHD_SWEEP_FRAMES;
    localparam int TIMEOUT_CYCLES = 2 * RUN_FRAMES * FRAME_CYCLES + 1000;
    localparam int RUN1_STROBES   = 2 * `RHD_NUM_CHANNELS;
    localparam int RUN2_STROBES   = `RHD_FIFO_DEPTH + `RHD_NUM_CHANNELS;
    localparam int CORRUPT_REG    = 5;
    // Frame whose reply carries the corrupted acknowledgement
    localparam int BAD_ACK_FRAME  = `RHD_PRE_READS + CORRUPT_REG + 2;

    logic        clk80;
    logic        reset_n;
    logic        host_en;
    logic        corrupt_ack;
    logic        rhd_cs;
    logic        rhd_sck;
    logic        rhd_mosi;
    logic        rhd_miso;
    rhd_sample_t sample_out;
    logic        sample_strobe;
    logic        overrun;
    logic        config_error;

    int          cycle = 0;
    int          strobe_cycle = 0;
    bit          have_strobe = 1'b0;
    int          frames_sent = 0;
    logic        cs_prev = 1'b1;
    rhd_sample_t strobe_q [$];
    rhd_sample_t expected_q [$];

    rhd_acq_top rhd_acq_top_i (
        .clk80         (clk80),
        .reset_n       (reset_n),
        .rhd_cs        (rhd_cs),
        .rhd_sck       (rhd_sck),
        .rhd_mosi      (rhd_mosi),
        .rhd_miso      (rhd_miso),
        .host_en       (host_en),
        .sample_out    (sample_out),
        .sample_strobe (sample_strobe),
        .overrun       (overrun),
        .config_error  (config_error)
    );

    rhd_chip_model #(.CORRUPT_REG(CORRUPT_REG)) chip_model_i (
        .reset_n     (reset_n),
        .corrupt_ack (corrupt_ack),
        .rhd_cs      (rhd_cs),
        .rhd_sck     (rhd_sck),
        .rhd_mosi    (rhd_mosi),
        .rhd_miso    (rhd_miso)
    );

    bind rhd_acq_top rhd_acq_props rhd_acq_props_i (
        .clk80         (clk80),
        .reset_n       (reset_n),
        .rhd_cs        (rhd_cs),
        .rhd_sck       (rhd_sck),
        .host_en       (host_en),
        .sample_strobe (sample_strobe)
    );

    initial clk80 = 1'b0;
    always #2 clk80 = ~clk80;

    ////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, expected);
        stop_on_error();
    endtask

    task automatic abort_run(string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        stop_on_error();
    endtask

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////

    // Host enable and the corrupt flag change only while reset is held
    task automatic apply_reset(logic en, logic corrupt);
        reset_n     = 1'b1;
        host_en     = en;
        corrupt_ack = corrupt;
        repeat (3) @(negedge clk80);
        reset_n = 1'b0;
    endtask

    task automatic wait_strobes(int count);
        while (strobe_q.size() < count) begin
            @(negedge clk80);
        end
    endtask

    // Power-up order, then convert fields 0 to 34 over and over
    function automatic rhd_word_t expected_command(int idx);
        int pos;
        pos = idx;
        if (pos < `RHD_PRE_READS) begin
            return rhd_pkg::CMD_READ63;
        end
        pos = pos - `RHD_PRE_READS;
        if (pos < `RHD_REG_COUNT) begin
            return {2'b10, 6'(pos), rhd_pkg::rhd_reg_table[5'(pos)]};
        end
        pos = pos - `RHD_REG_COUNT;
        if (pos == 0) begin
            return rhd_pkg::CMD_CALIBRATE;
        end
        pos = pos - 1;
        if (pos < `RHD_POST_READS) begin
            return rhd_pkg::CMD_READ63;
        end
        pos = pos - `RHD_POST_READS;
        return rhd_pkg::CMD_CONVERT_OP | {2'b00, 6'(pos % `RHD_SWEEP_FRAMES), 8'h00};
    endfunction

    task automatic check_commands();
        rhd_word_t expected;
        if (chip_model_i.cmd_log.size() < BOOT_FRAMES + `RHD_SWEEP_FRAMES) begin
            abort_run("Too few commands were seen on MOSI");
        end
        for (int idx = 0; idx < chip_model_i.cmd_log.size(); idx++) begin
            expected = expected_command(idx);
            assert (chip_model_i.cmd_log[idx] == expected)
                else report_mismatch($sformatf("rhd_mosi command #%0d", idx),
                    32'(chip_model_i.cmd_log[idx]), 32'(expected));
        end
    endtask

    // Convert fields 0 to 31 in logged order give the sample list
    task automatic build_expected();
        rhd_sample_t entry;
        expected_q.delete();
        for (int idx = 0; idx < chip_model_i.conv_chan.size(); idx++) begin
            if (chip_model_i.conv_chan[idx] < 6'(`RHD_NUM_CHANNELS)) begin
                entry.chan = 5'(chip_model_i.conv_chan[idx]);
                entry.data = chip_model_i.conv_data[idx];
                expected_q.push_back(entry);
            end
        end
    endtask

    task automatic check_in_order(int count);
        build_expected();
        assert (expected_q.size() >= count)
            else abort_run("The chip model logged fewer conversions than samples seen");
        for (int idx = 0; idx < count; idx++) begin
            assert (strobe_q[idx].chan == expected_q[idx].chan)
                else report_mismatch($sformatf("sample_out.chan #%0d", idx),
                    32'(strobe_q[idx].chan), 32'(expected_q[idx].chan));
            assert (strobe_q[idx].data == expected_q[idx].data)
                else report_mismatch($sformatf("sample_out.data #%0d", idx),
                    32'(strobe_q[idx].data), 32'(expected_q[idx].data));
        end
    endtask

    // Later samples may skip dropped entries but never repeat or reorder
    task automatic check_subsequence(int first);
        int  pos;
        bit  found;
        build_expected();
        pos = first - 1;
        for (int idx = first; idx < strobe_q.size(); idx++) begin
            found = 1'b0;
            while (!found && pos + 1 < expected_q.size()) begin
                pos++;
                found = strobe_q[idx] == expected_q[pos];
            end
            assert (found)
                else abort_run($sformatf("Sample #%0d is out of order or repeated", idx));
        end
    endtask

    ////////////////////////////////////////
    // Output monitor and timeout
    ////////////////////////////////////////

    always @(negedge clk80) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            abort_run("Timeout, the expected samples did not arrive within the cycle limit");
        end else if (reset_n) begin
            have_strobe = 1'b0;
            frames_sent = 0;
            cs_prev     = 1'b1;
            strobe_q.delete();
        end else begin
            // Chip select rises once the 16 bits of a frame are out
            if (rhd_cs && !cs_prev) begin
                frames_sent++;
            end
            cs_prev = rhd_cs;
            if (corrupt_ack && frames_sent >= BAD_ACK_FRAME + 2) begin
                assert (config_error)
                    else report_mismatch("config_error", 32'(config_error), 32'd1);
            end else if (!corrupt_ack || frames_sent <= BAD_ACK_FRAME) begin
                assert (!config_error)
                    else report_mismatch("config_error", 32'(config_error), 32'd0);
            end
            // Only the second run lets the FIFO overflow
            if (!corrupt_ack) begin
                assert (!overrun) else report_mismatch("overrun", 32'(overrun), 32'd0);
            end
            if (sample_strobe) begin
                assert (host_en) else abort_run("Sample strobe while host enable is low");
                if (have_strobe) begin
                    assert (cycle - strobe_cycle >= `RHD_OUT_GAP)
                        else abort_run("Two sample strobes closer than the pacing interval");
                end
                strobe_q.push_back(sample_out);
                have_strobe  = 1'b1;
                strobe_cycle = cycle;
            end
        end
    end

    initial begin
        reset_n     = 1'b1;
        host_en     = 1'b0;
        corrupt_ack = 1'b0;

        // Correct acknowledgements, host always reading
        apply_reset(1'b1, 1'b0);
        wait_strobes(RUN1_STROBES);
        check_commands();
        check_in_order(RUN1_STROBES);

        // One bad acknowledgement, host held off until the FIFO overflows
        apply_reset(1'b0, 1'b1);
        while (!overrun) begin
            @(negedge clk80);
        end
        host_en = 1'b1;
        wait_strobes(RUN2_STROBES);
        check_in_order(`RHD_FIFO_DEPTH);
        check_subsequence(`RHD_FIFO_DEPTH);
        assert (config_error) else report_mismatch("config_error", 32'(config_error), 32'd1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* dv/rhd_acq_props.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module rhd_acq_props (
    input logic clk80,
    input logic reset_n,
    input logic rhd_cs,
    input logic rhd_sck,
    input logic host_en,
    input logic sample_strobe
);
    localparam int CS_LOW_CYCLES = `RHD_CMD_BITS * `RHD_SCK_DIV;

    int cs_low_cnt;

    // Length of the current chip select low stretch
    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            cs_low_cnt <= 0;
        end else if (!rhd_cs) begin
            cs_low_cnt <= cs_low_cnt + 1;
        end else begin
            cs_low_cnt <= 0;
        end
    end

    sck_parked: assert property (@(posedge clk80) disable iff (reset_n)
        rhd_cs |-> !rhd_sck)
        else $error("SCK high while chip select is high");

    cs_low_length: assert property (@(posedge clk80) disable iff (reset_n)
        $rose(rhd_cs) |-> cs_low_cnt == CS_LOW_CYCLES)
        else $error("Chip select low for %0d cycles", cs_low_cnt);

    strobe_needs_enable: assert property (@(posedge clk80) disable iff (reset_n)
        !host_en |-> !sample_strobe)
        else $error("Sample strobe while host enable is low");

endmodule

/* dv/rhd_chip_model.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module rhd_chip_model #(
    parameter int CORRUPT_REG = 5
) (
    input  logic reset_n,
    input  logic corrupt_ack,
    input  logic rhd_cs,
    input  logic rhd_sck,
    input  logic rhd_mosi,
    output logic rhd_miso
);
    import rhd_pkg::*;

    integer     seed = 32;
    logic       miso_q = 1'b0;
    logic [4:0] bit_cnt;
    rhd_word_t  rx_cmd;
    // Reply for the next frame, then the one after it
    rhd_word_t  cur_reply;
    rhd_word_t  next_reply;

    // Logs read by the testbench
    rhd_word_t  cmd_log [$];
    rhd_field_t conv_chan [$];
    rhd_word_t  conv_data [$];

    assign rhd_miso = miso_q;

    // MOSI is stable at the falling SCK edge
    always @(negedge rhd_sck or posedge reset_n) begin
        rhd_word_t cmd;
        rhd_word_t reply;
        if (reset_n) begin
            bit_cnt    = '0;
            cur_reply  = 16'h0000;
            next_reply = 16'h0000;
            cmd_log.delete();
            conv_chan.delete();
            conv_data.delete();
        end else if (!rhd_cs) begin
            cmd     = {rx_cmd[14:0], rhd_mosi};
            rx_cmd  = cmd;
            bit_cnt = bit_cnt + 1'b1;
            if (bit_cnt == 5'd16) begin
                bit_cnt = '0;
                cmd_log.push_back(cmd);
                case (cmd[15:14])
                    2'b10: begin
                        reply = {8'hFF, cmd[7:0]};
                        if (corrupt_ack && cmd[13:8] == 6'(CORRUPT_REG)) begin
                            reply[0] = !reply[0];
                        end
                    end
                    2'b00: begin
                        reply = 16'($random(seed));
                        conv_chan.push_back(cmd[13:8]);
                        conv_data.push_back(reply);
                    end
                    default: reply = 16'hFFFF;
                endcase
                // Two frame pipeline
                cur_reply  = next_reply;
                next_reply = reply;
            end
        end
    end

    // New bit goes out as SCK rises, well before the capture edge
    always @(posedge rhd_sck) begin
        miso_q <= cur_reply[4'(15 - bit_cnt)];
    end

endmodule

/* source/rhd_acq_top.sv */
`timescale 1ns/100ps

module rhd_acq_top (
    input  logic                 clk80,
    input  logic                 reset_n,
    // Chip SPI pins
    output logic                 rhd_cs,
    output logic                 rhd_sck,
    output logic                 rhd_mosi,
    input  logic                 rhd_miso,
    // Host side
    input  logic                 host_en,
    output rhd_pkg::rhd_sample_t sample_out,
    output logic                 sample_strobe,
    output logic                 overrun,
    output logic                 config_error
);
    import rhd_pkg::*;

    logic        push;
    rhd_sample_t push_sample;
    logic        pop;
    logic        empty;
    rhd_sample_t head;

    rhd_sequencer rhd_sequencer_i (
        .clk80        (clk80),
        .reset_n      (reset_n),
        .rhd_miso     (rhd_miso),
        .rhd_cs       (rhd_cs),
        .rhd_sck      (rhd_sck),
        .rhd_mosi     (rhd_mosi),
        .push         (push),
        .push_sample  (push_sample),
        .config_error (config_error)
    );

    sample_fifo sample_fifo_i (
        .clk80       (clk80),
        .reset_n     (reset_n),
        .push        (push),
        .push_sample (push_sample),
        .pop         (pop),
        .head        (head),
        .empty       (empty),
        .overrun     (overrun)
    );

    sample_reader sample_reader_i (
        .clk80         (clk80),
        .reset_n       (reset_n),
        .host_en       (host_en),
        .empty         (empty),
        .head          (head),
        .pop           (pop),
        .sample_out    (sample_out),
        .sample_strobe (sample_strobe)
    );

endmodule

/* source/sample_reader.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module sample_reader (
    input  logic                 clk80,
    input  logic                 reset_n,
    input  logic                 host_en,
    input  logic                 empty,
    input  rhd_pkg::rhd_sample_t head,
    output logic                 pop,
    output rhd_pkg::rhd_sample_t sample_out,
    output logic                 sample_strobe
);
    localparam int GAP_W = $clog2(`RHD_OUT_GAP);

    localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(`RHD_OUT_GAP - 1);

    logic [GAP_W-1:0] gap_cnt;

    // Zero count means the pacing interval has passed
    assign pop = host_en && !empty && gap_cnt == '0;

    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            gap_cnt       <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= pop;
            if (pop) begin
                gap_cnt <= GAP_LOAD;
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    // Output register, qualified by the strobe
    always_ff @(posedge clk80) begin
        if (pop) begin
            sample_out <= head;
        end
    end

endmodule

/* source/sample_fifo.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module sample_fifo (
    input  logic                 clk80,
    input  logic                 reset_n,
    input  logic                 push,
    input  rhd_pkg::rhd_sample_t push_sample,
    input  logic                 pop,
    output rhd_pkg::rhd_sample_t head,
    output logic                 empty,
    output logic                 overrun
);
    import rhd_pkg::*;

    localparam int PTR_W   = $clog2(`RHD_FIFO_DEPTH);
    localparam int COUNT_W = PTR_W + 1;

    localparam logic [PTR_W-1:0]   PTR_LAST   = PTR_W'(`RHD_FIFO_DEPTH - 1);
    localparam logic [COUNT_W-1:0] COUNT_FULL = COUNT_W'(`RHD_FIFO_DEPTH);

    rhd_sample_t        mem [`RHD_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = count == COUNT_FULL;
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead
    assign head = mem[rd_ptr];

    always_ff @(posedge clk80) begin
        if (do_push) begin
            mem[wr_ptr] <= push_sample;
        end
    end

    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + COUNT_W'(do_push) - COUNT_W'(do_pop);
            // Dropped sample, held until reset
            if (push && full) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

/* source/rhd_sequencer.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module rhd_sequencer (
    input  logic                 clk80,
    input  logic                 reset_n,
    input  logic                 rhd_miso,
    output logic                 rhd_cs,
    output logic                 rhd_sck,
    output logic                 rhd_mosi,
    output logic                 push,
    output rhd_pkg::rhd_sample_t push_sample,
    output logic                 config_error
);
    import rhd_pkg::*;

    localparam int REG_IDX_W = $clog2(`RHD_REG_COUNT);

    seq_state_t state;
    rhd_field_t frame_idx;
    logic       started;
    logic       frame_start;
    logic       frame_done;
    rhd_word_t  cmd_word;
    rhd_word_t  reply_word;
    rhd_byte_t  table_byte;
    logic       is_sample_frame;
    logic       ack_bad;
    logic [1:0] ack_valid;
    rhd_word_t  ack_expect [2];

    rhd_spi_frame rhd_spi_frame_i (
        .clk80       (clk80),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .cmd_word    (cmd_word),
        .rhd_miso    (rhd_miso),
        .rhd_cs      (rhd_cs),
        .rhd_sck     (rhd_sck),
        .rhd_mosi    (rhd_mosi),
        .frame_done  (frame_done),
        .reply_word  (reply_word)
    );

    // First frame right out of reset, then back to back
    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            started     <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            started     <= 1'b1;
            frame_start <= !started || frame_done;
        end
    end

    ////////////////////////////////////////
    // Command of the frame in flight
    ////////////////////////////////////////

    always_comb begin
        table_byte = '0;
        if (frame_idx < rhd_field_t'(`RHD_REG_COUNT)) begin
            table_byte = rhd_reg_table[REG_IDX_W'(frame_idx)];
        end
        case (state)
            WRITE_REGS: cmd_word = {CMD_WRITE_PREFIX, frame_idx, table_byte};
            CALIBRATE:  cmd_word = CMD_CALIBRATE;
            CONVERT:    cmd_word = CMD_CONVERT_OP | {2'b00, frame_idx, 8'h00};
            default:    cmd_word = CMD_READ63;
        endcase
    end

    // Advance once the current frame completes
    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            state     <= DUMMY_PRE;
            frame_idx <= '0;
        end else if (frame_done) begin
            frame_idx <= frame_idx + 1'b1;
            case (state)
                DUMMY_PRE: begin
                    if (frame_idx == rhd_field_t'(`RHD_PRE_READS - 1)) begin
                        state     <= WRITE_REGS;
                        frame_idx <= '0;
                    end
                end
                WRITE_REGS: begin
                    if (frame_idx == rhd_field_t'(`RHD_REG_COUNT - 1)) begin
                        state     <= CALIBRATE;
                        frame_idx <= '0;
                    end
                end
                CALIBRATE: begin
                    state     <= DUMMY_POST;
                    frame_idx <= '0;
                end
                DUMMY_POST: begin
                    if (frame_idx == rhd_field_t'(`RHD_POST_READS - 1)) begin
                        state     <= CONVERT;
                        frame_idx <= '0;
                    end
                end
                default: begin
                    if (frame_idx == rhd_field_t'(`RHD_SWEEP_FRAMES - 1)) begin
                        frame_idx <= '0;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Samples and acknowledgements
    ////////////////////////////////////////

    // Reply of frame i belongs to channel i - 2
    assign is_sample_frame = state == CONVERT
        && frame_idx >= rhd_field_t'(`RHD_FIRST_SAMPLE)
        && frame_idx < rhd_field_t'(`RHD_FIRST_SAMPLE + `RHD_NUM_CHANNELS);

    // Slot 1 holds the expectation for the frame two back
    assign ack_bad = frame_done && ack_valid[1] && reply_word != ack_expect[1];

    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            push         <= 1'b0;
            ack_valid    <= '0;
            config_error <= 1'b0;
        end else begin
            push <= frame_done && is_sample_frame;
            if (frame_done) begin
                ack_valid <= {ack_valid[0], state == WRITE_REGS};
            end
            if (ack_bad) begin
                config_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk80) begin
        if (frame_done) begin
            ack_expect[1] <= ack_expect[0];
            ack_expect[0] <= {WRITE_ACK_BYTE, table_byte};
        end
        if (frame_done && is_sample_frame) begin
            push_sample.chan <= rhd_chan_t'(frame_idx - rhd_field_t'(`RHD_FIRST_SAMPLE));
            push_sample.data <= reply_word;
        end
    end

endmodule

/* source/rhd_spi_frame.sv */
`timescale 1ns/100ps
`include "rhd_defs.svh"

module rhd_spi_frame (
    input  logic               clk80,
    input  logic               reset_n,
    input  logic               frame_start,
    input  rhd_pkg::rhd_word_t cmd_word,
    input  logic               rhd_miso,
    output logic               rhd_cs,
    output logic               rhd_sck,
    output logic               rhd_mosi,
    output logic               frame_done,
    output rhd_pkg::rhd_word_t reply_word
);
    import rhd_pkg::*;

    localparam int PHASE_W = $clog2(`RHD_SCK_DIV);
    localparam int SLOT_W  = $clog2(`RHD_FRAME_SLOTS);

    localparam logic [PHASE_W-1:0] PHASE_FALL = PHASE_W'(`RHD_SCK_DIV / 2 - 1);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`RHD_SCK_DIV - 1);
    localparam logic [SLOT_W-1:0]  SLOT_BITS  = SLOT_W'(`RHD_CMD_BITS);
    localparam logic [SLOT_W-1:0]  SLOT_LAST  = SLOT_W'(`RHD_FRAME_SLOTS - 1);

    logic               busy;
    logic [PHASE_W-1:0] phase;
    logic [SLOT_W-1:0]  slot;
    logic               in_bits;
    logic               end_of_slot;
    rhd_word_t          tx_shift;
    rhd_word_t          rx_shift;

    assign in_bits     = slot < SLOT_BITS;
    assign end_of_slot = phase == PHASE_LAST;

    // Phase within an SCK period and slot within the frame
    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            busy  <= 1'b0;
            phase <= '0;
            slot  <= '0;
        end else if (frame_start) begin
            busy  <= 1'b1;
            phase <= '0;
            slot  <= '0;
        end else if (busy) begin
            if (end_of_slot) begin
                phase <= '0;
                slot  <= slot + 1'b1;
                if (slot == SLOT_LAST) begin
                    busy <= 1'b0;
                    slot <= '0;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Chip pins
    ////////////////////////////////////////

    always_ff @(posedge clk80 or posedge reset_n) begin
        if (reset_n) begin
            rhd_cs   <= 1'b1;
            rhd_sck  <= 1'b0;
            rhd_mosi <= 1'b0;
        end else if (frame_start) begin
            rhd_cs   <= 1'b0;
            rhd_sck  <= 1'b1;
            rhd_mosi <= cmd_word[15];
        end else if (busy && in_bits) begin
            if (phase == PHASE_FALL) begin
                rhd_sck <= 1'b0;
            end
            if (end_of_slot) begin
                if (slot == SLOT_BITS - 1'b1) begin
                    // Last bit done, gap starts with SCK parked low
                    rhd_cs   <= 1'b1;
                    rhd_mosi <= 1'b0;
                end else begin
                    rhd_sck  <= 1'b1;
                    rhd_mosi <= tx_shift[15];
                end
            end
        end
    end

    // MSB first out, MISO taken as SCK falls
    always_ff @(posedge clk80) begin
        if (frame_start) begin
            tx_shift <= {cmd_word[14:0], 1'b0};
        end else if (busy && in_bits && end_of_slot) begin
            tx_shift <= {tx_shift[14:0], 1'b0};
        end
        if (busy && in_bits && phase == PHASE_FALL) begin
            rx_shift <= {rx_shift[14:0], rhd_miso};
        end
    end

    assign frame_done = busy && slot == SLOT_LAST && end_of_slot;
    assign reply_word = rx_shift;

endmodule

/* source/rhd_pkg.sv */
`include "rhd_defs.svh"

package rhd_pkg;

    ////////////////////////////////////////
    // Word and field types
    ////////////////////////////////////////

    // One SPI command or reply
    typedef logic [15:0] rhd_word_t;
    typedef logic [7:0]  rhd_byte_t;
    // Register number or channel field inside a command
    typedef logic [5:0]  rhd_field_t;
    typedef logic [4:0]  rhd_chan_t;

    typedef struct packed {
        rhd_chan_t chan;
        rhd_word_t data;
    } rhd_sample_t;

    // Power-up order, then sweeps forever
    typedef enum logic [2:0] {
        DUMMY_PRE,
        WRITE_REGS,
        CALIBRATE,
        DUMMY_POST,
        CONVERT
    } seq_state_t;

    ////////////////////////////////////////
    // Command opcodes
    ////////////////////////////////////////

    // Read of register 63
    localparam rhd_word_t CMD_READ63     = 16'hFF00;
    localparam rhd_word_t CMD_CALIBRATE  = 16'h5500;
    // Channel goes in bits 13:8
    localparam rhd_word_t CMD_CONVERT_OP = 16'h0000;

    localparam logic [1:0] CMD_WRITE_PREFIX = 2'b10;
    // Upper byte of every write acknowledgement
    localparam rhd_byte_t  WRITE_ACK_BYTE   = 8'hFF;

    // Register contents, written to registers 0 to 17 in order
    localparam rhd_byte_t rhd_reg_table [`RHD_REG_COUNT] = '{
        8'hDE, 8'h04, 8'h12, 8'h00,
        8'h80, 8'h00, 8'h80, 8'h00,
        8'h16, 8'h80, 8'h17, 8'h80,
        8'h2C, 8'h86, 8'hFF, 8'hFF,
        8'hFF, 8'hFF
    };

endpackage

/* include/rhd_defs.svh */
`ifndef RHD_DEFS_SVH
`define RHD_DEFS_SVH

////////////////////////////////////////
// SPI frame timing
////////////////////////////////////////

// clk80 cycles per SCK period, SCK high in the first half
`define RHD_SCK_DIV 4
// Bit slots with chip select low
`define RHD_CMD_BITS 16
// Total slots per frame including the chip select high gap
`define RHD_FRAME_SLOTS 28

////////////////////////////////////////
// Command sequence
////////////////////////////////////////

`define RHD_PRE_READS 2
`define RHD_REG_COUNT 18
`define RHD_POST_READS 9
`define RHD_SWEEP_FRAMES 35

// Chip pipeline delay in frames
`define RHD_FIRST_SAMPLE 2
`define RHD_NUM_CHANNELS 32

// Sample buffering and host pacing in clk80 cycles
`define RHD_FIFO_DEPTH 16
`define RHD_OUT_GAP 8

`endif
